/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_wb_subsystem
FILELIST  = src.f
OBJDIR    = obj_dir
PASS_MSG  = Test passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

/* source/completion_table.sv */
`timescale 1ns/1ps

module completion_table (
    input  logic                         clk_i,
    input  logic                         rstn_i,

    input  logic                         rf_valid_i,
    input  logic [core_pkg::TAG_BIT-1:0] rf_tag_i,
    input  logic                         csr_valid_i,
    input  logic [core_pkg::TAG_BIT-1:0] csr_tag_i,

    input  logic                         alloc_valid_i,
    input  logic [core_pkg::TAG_BIT-1:0] alloc_tag_i,

    output logic [core_pkg::TAG_COUNT-1:0] done_o
);

    import core_pkg::*;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            done_o <= '0;
        end else begin
            for (int t = 0; t < TAG_COUNT; t++) begin
                // Set has priority over a same-edge allocation
                if ((rf_valid_i && (rf_tag_i == TAG_BIT'(t))) ||
                    (csr_valid_i && (csr_tag_i == TAG_BIT'(t)))) begin
                    done_o[t] <= 1'b1;
                end else if (alloc_valid_i && (alloc_tag_i == TAG_BIT'(t))) begin
                    done_o[t] <= 1'b0;
                end
            end
        end
    end

endmodule

/* source/core_pkg.sv */
package core_pkg;

    // Datapath widths
    localparam int DATA_BIT     = 32;
    localparam int REG_ADDR_BIT = 5;
    localparam int TAG_BIT      = 4;
    localparam int TAG_COUNT    = 16;

    // Executed micro-op word, fields packed from bit 0 upward
    localparam int UOP_BIT = 88;

    localparam int UOP_VALID_LO = 0;
    localparam int UOP_VALID_HI = 0;

    localparam int UOP_TAG_LO = 1;
    localparam int UOP_TAG_HI = 4;

    // Integer register write
    localparam int UOP_RD_ALLOC_LO = 5;
    localparam int UOP_RD_ALLOC_HI = 5;

    localparam int UOP_RD_ADDR_LO = 6;
    localparam int UOP_RD_ADDR_HI = 10;

    localparam int UOP_RD_LO = 11;
    localparam int UOP_RD_HI = 42;

    // CSR write
    localparam int UOP_CSR_ALLOC_LO = 43;
    localparam int UOP_CSR_ALLOC_HI = 43;

    localparam int UOP_CSR_ADDR_LO = 44;
    localparam int UOP_CSR_ADDR_HI = 55;

    localparam int UOP_CSR_LO = 56;
    localparam int UOP_CSR_HI = 87;

endpackage

/* source/csr_file.sv */
`timescale 1ns/1ps

module csr_file (
    input  logic                             clk_i,
    input  logic                             rstn_i,

    input  logic                             we_i,
    input  logic [csr_pkg::CSR_ADDR_BIT-1:0] waddr_i,
    input  logic [core_pkg::DATA_BIT-1:0]    wdata_i,

    input  logic [csr_pkg::CSR_ADDR_BIT-1:0] raddr_i,
    output logic [core_pkg::DATA_BIT-1:0]    rdata_o
);

    import core_pkg::*;
    import csr_pkg::*;

    logic [DATA_BIT-1:0] mtvec_q;
    logic [DATA_BIT-1:0] mscratch_q;
    logic [DATA_BIT-1:0] mepc_q;
    logic [DATA_BIT-1:0] mcause_q;

    csr_addr_u waddr_u;
    logic      write_ok;

    assign waddr_u.raw = waddr_i;

    // Read-only space is decided by the access bits alone
    assign write_ok = we_i && (waddr_u.fields.access != CSR_ACCESS_RO);

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            mtvec_q    <= '0;
            mscratch_q <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
        end else if (write_ok) begin
            case (waddr_u.raw)
                CSR_MTVEC: begin
                    mtvec_q <= wdata_i;
                end
                CSR_MSCRATCH: begin
                    mscratch_q <= wdata_i;
                end
                CSR_MEPC: begin
                    mepc_q <= wdata_i;
                end
                CSR_MCAUSE: begin
                    mcause_q <= wdata_i;
                end
                default: begin
                    // Unimplemented, write has no effect
                end
            endcase
        end
    end

    always_comb begin
        case (raddr_i)
            CSR_MTVEC: begin
                rdata_o = mtvec_q;
            end
            CSR_MSCRATCH: begin
                rdata_o = mscratch_q;
            end
            CSR_MEPC: begin
                rdata_o = mepc_q;
            end
            CSR_MCAUSE: begin
                rdata_o = mcause_q;
            end
            CSR_MHARTID: begin
                rdata_o = HART_ID;
            end
            default: begin
                rdata_o = '0;
            end
        endcase
    end

endmodule

/* source/csr_pkg.sv */
package csr_pkg;

    localparam int CSR_ADDR_BIT = 12;

    // Implemented machine-mode CSRs
    localparam logic [CSR_ADDR_BIT-1:0] CSR_MTVEC    = 12'h305;
    localparam logic [CSR_ADDR_BIT-1:0] CSR_MSCRATCH = 12'h340;
    localparam logic [CSR_ADDR_BIT-1:0] CSR_MEPC     = 12'h341;
    localparam logic [CSR_ADDR_BIT-1:0] CSR_MCAUSE   = 12'h342;
    localparam logic [CSR_ADDR_BIT-1:0] CSR_MHARTID  = 12'hF14;

    localparam logic [31:0] HART_ID = 32'd0;

    // Access encoding in the top two address bits
    localparam logic [1:0] CSR_ACCESS_RO = 2'b11;

    typedef struct packed {
        logic [1:0] access;
        logic [1:0] priv;
        logic [7:0] index;
    } csr_addr_fields_t;

    // Same address seen flat or split by the privileged spec layout
    typedef union packed {
        logic [CSR_ADDR_BIT-1:0] raw;
        csr_addr_fields_t        fields;
    } csr_addr_u;

endpackage

/* source/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic                              clk_i,
    input  logic                              rstn_i,

    input  logic                              we_i,
    input  logic [core_pkg::REG_ADDR_BIT-1:0] waddr_i,
    input  logic [core_pkg::DATA_BIT-1:0]     wdata_i,

    input  logic [core_pkg::REG_ADDR_BIT-1:0] raddr1_i,
    input  logic [core_pkg::REG_ADDR_BIT-1:0] raddr2_i,
    output logic [core_pkg::DATA_BIT-1:0]     rdata1_o,
    output logic [core_pkg::DATA_BIT-1:0]     rdata2_o
);

    import core_pkg::*;

    localparam int REG_COUNT = 2 ** REG_ADDR_BIT;

    // x0 has no storage
    logic [DATA_BIT-1:0] regs [1:REG_COUNT-1];

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            for (int i = 1; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // Reads see the value before this cycle's write
    always_comb begin
        rdata1_o = '0;
        rdata2_o = '0;
        if (raddr1_i != '0) begin
            rdata1_o = regs[raddr1_i];
        end
        if (raddr2_i != '0) begin
            rdata2_o = regs[raddr2_i];
        end
    end

endmodule

/* source/wb_subsystem.sv */
`timescale 1ns/1ps

module wb_subsystem (
    input  logic                              clk_i,
    input  logic                              rstn_i,

    input  logic [core_pkg::UOP_BIT-1:0]      uop_i,

    input  logic                              alloc_valid_i,
    input  logic [core_pkg::TAG_BIT-1:0]      alloc_tag_i,

    input  logic [core_pkg::REG_ADDR_BIT-1:0] rs1_addr_i,
    input  logic [core_pkg::REG_ADDR_BIT-1:0] rs2_addr_i,
    output logic [core_pkg::DATA_BIT-1:0]     rs1_data_o,
    output logic [core_pkg::DATA_BIT-1:0]     rs2_data_o,

    input  logic [csr_pkg::CSR_ADDR_BIT-1:0]  csr_raddr_i,
    output logic [core_pkg::DATA_BIT-1:0]     csr_rdata_o,

    output logic [core_pkg::TAG_COUNT-1:0]    done_o
);

    import core_pkg::*;
    import csr_pkg::*;

    // Register write port
    logic                    rf_valid;
    logic [REG_ADDR_BIT-1:0] rf_addr;
    logic [DATA_BIT-1:0]     rf_data;
    logic [TAG_BIT-1:0]      rf_tag;

    // CSR write port
    logic                    csr_valid;
    logic [CSR_ADDR_BIT-1:0] csr_addr;
    logic [DATA_BIT-1:0]     csr_data;
    logic [TAG_BIT-1:0]      csr_tag;

    writeback_stage u_writeback_stage (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .uop_i       (uop_i),
        .rf_valid_o  (rf_valid),
        .rf_addr_o   (rf_addr),
        .rf_data_o   (rf_data),
        .rf_tag_o    (rf_tag),
        .csr_valid_o (csr_valid),
        .csr_addr_o  (csr_addr),
        .csr_data_o  (csr_data),
        .csr_tag_o   (csr_tag)
    );

    reg_file u_reg_file (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .we_i     (rf_valid),
        .waddr_i  (rf_addr),
        .wdata_i  (rf_data),
        .raddr1_i (rs1_addr_i),
        .raddr2_i (rs2_addr_i),
        .rdata1_o (rs1_data_o),
        .rdata2_o (rs2_data_o)
    );

    csr_file u_csr_file (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .we_i    (csr_valid),
        .waddr_i (csr_addr),
        .wdata_i (csr_data),
        .raddr_i (csr_raddr_i),
        .rdata_o (csr_rdata_o)
    );

    completion_table u_completion_table (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .rf_valid_i    (rf_valid),
        .rf_tag_i      (rf_tag),
        .csr_valid_i   (csr_valid),
        .csr_tag_i     (csr_tag),
        .alloc_valid_i (alloc_valid_i),
        .alloc_tag_i   (alloc_tag_i),
        .done_o        (done_o)
    );

endmodule

/* source/writeback_stage.sv */
`timescale 1ns/1ps

module writeback_stage (
    input  logic                             clk_i,
    input  logic                             rstn_i,

    input  logic [core_pkg::UOP_BIT-1:0]     uop_i,

    output logic                             rf_valid_o,
    output logic [core_pkg::REG_ADDR_BIT-1:0] rf_addr_o,
    output logic [core_pkg::DATA_BIT-1:0]    rf_data_o,
    output logic [core_pkg::TAG_BIT-1:0]     rf_tag_o,

    output logic                             csr_valid_o,
    output logic [csr_pkg::CSR_ADDR_BIT-1:0] csr_addr_o,
    output logic [core_pkg::DATA_BIT-1:0]    csr_data_o,
    output logic [core_pkg::TAG_BIT-1:0]     csr_tag_o
);

    import core_pkg::*;
    import csr_pkg::*;

    logic                    uop_valid;
    logic [TAG_BIT-1:0]      uop_tag;
    logic                    uop_rd_alloc;
    logic [REG_ADDR_BIT-1:0] uop_rd_addr;
    logic [DATA_BIT-1:0]     uop_rd;
    logic                    uop_csr_alloc;
    logic [CSR_ADDR_BIT-1:0] uop_csr_addr;
    logic [DATA_BIT-1:0]     uop_csr;

    // Field slicing
    assign uop_valid     = uop_i[UOP_VALID_HI:UOP_VALID_LO];
    assign uop_tag       = uop_i[UOP_TAG_HI:UOP_TAG_LO];
    assign uop_rd_alloc  = uop_i[UOP_RD_ALLOC_HI:UOP_RD_ALLOC_LO];
    assign uop_rd_addr   = uop_i[UOP_RD_ADDR_HI:UOP_RD_ADDR_LO];
    assign uop_rd        = uop_i[UOP_RD_HI:UOP_RD_LO];
    assign uop_csr_alloc = uop_i[UOP_CSR_ALLOC_HI:UOP_CSR_ALLOC_LO];
    assign uop_csr_addr  = uop_i[UOP_CSR_ADDR_HI:UOP_CSR_ADDR_LO];
    assign uop_csr       = uop_i[UOP_CSR_HI:UOP_CSR_LO];

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            rf_valid_o  <= 1'b0;
            rf_addr_o   <= '0;
            rf_data_o   <= '0;
            rf_tag_o    <= '0;
            csr_valid_o <= 1'b0;
            csr_addr_o  <= '0;
            csr_data_o  <= '0;
            csr_tag_o   <= '0;
        end else begin
            // A port fires only when the micro-op asked for that write
            rf_valid_o  <= uop_valid && uop_rd_alloc;
            rf_addr_o   <= uop_rd_addr;
            rf_data_o   <= uop_rd;
            rf_tag_o    <= uop_tag;

            csr_valid_o <= uop_valid && uop_csr_alloc;
            csr_addr_o  <= uop_csr_addr;
            csr_data_o  <= uop_csr;
            csr_tag_o   <= uop_tag;
        end
    end

endmodule

/* src.f */
source/core_pkg.sv
source/csr_pkg.sv
source/writeback_stage.sv
source/reg_file.sv
source/csr_file.sv
source/completion_table.sv
source/wb_subsystem.sv
verif/tb_wb_subsystem.sv

/* verif/tb_wb_subsystem.sv */
`timescale 1ns/1ps

module tb_wb_subsystem;

    localparam int    HALF_PERIOD = 50;
    localparam string VECTOR_PATH = "verif/wb_vectors.txt";

    logic        clk_i;
    logic        rstn_i;
    logic [87:0] uop_i;
    logic        alloc_valid_i;
    logic [3:0]  alloc_tag_i;
    logic [4:0]  rs1_addr_i;
    logic [4:0]  rs2_addr_i;
    logic [31:0] rs1_data_o;
    logic [31:0] rs2_data_o;
    logic [11:0] csr_raddr_i;
    logic [31:0] csr_rdata_o;
    logic [15:0] done_o;

    // Reference model
    logic [31:0] model_regs [32];
    logic [31:0] model_csrs [logic [11:0]];
    logic [15:0] model_done;
    logic [15:0] set_now;
    logic [15:0] set_prev;
    logic [15:0] clr_now;

    int vector_errors;
    int model_errors;
    int checks;
    int since_uop;
    int cycle_count = 0;
    int cycle_limit = 0;

    wb_subsystem uut (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .uop_i         (uop_i),
        .alloc_valid_i (alloc_valid_i),
        .alloc_tag_i   (alloc_tag_i),
        .rs1_addr_i    (rs1_addr_i),
        .rs2_addr_i    (rs2_addr_i),
        .rs1_data_o    (rs1_data_o),
        .rs2_data_o    (rs2_data_o),
        .csr_raddr_i   (csr_raddr_i),
        .csr_rdata_o   (csr_rdata_o),
        .done_o        (done_o)
    );

    always #HALF_PERIOD clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Test failed");
            $finish;
        end
    end

    function automatic logic csr_writable(input logic [11:0] addr);
        return addr == 12'h305 || addr == 12'h340 || addr == 12'h341 || addr == 12'h342;
    endfunction

    function automatic logic [31:0] model_csr_read(input logic [11:0] addr);
        // mhartid is never stored, so it reads as hart 0
        return model_csrs.exists(addr) ? model_csrs[addr] : 32'h0;
    endfunction

    task automatic compare(input string label, input logic [31:0] expected,
                           input logic [31:0] model, input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            $display("FAIL %s expected 0x%08h actual 0x%08h", label, expected, actual);
            vector_errors++;
        end
        if (actual !== model) begin
            $display("FAIL %s (model) expected 0x%08h actual 0x%08h", label, model, actual);
            model_errors++;
        end
    endtask

    task automatic check_field_count(input string op, input int got, input int want);
        if (got != want) begin
            $display("Vector line for operation %s has %0d fields where %0d are needed",
                     op, got, want);
            vector_errors++;
        end
    endtask

    // One clock; done bits follow the two-edge write-back latency
    task automatic step_cycle();
        @(negedge clk_i);
        model_done    = (model_done & ~clr_now) | set_prev;
        set_prev      = set_now;
        set_now       = '0;
        clr_now       = '0;
        uop_i         = '0;
        alloc_valid_i = 1'b0;
        since_uop++;
    endtask

    task automatic wait_for_writes();
        while (since_uop < 2) begin
            step_cycle();
        end
    endtask

    task automatic sweep_after_reset();
        logic [11:0] writable [4] = '{12'h305, 12'h340, 12'h341, 12'h342};
        for (int i = 0; i < 32; i++) begin
            rs1_addr_i = 5'(i);
            rs2_addr_i = 5'(31 - i);
            #1;
            compare($sformatf("reset_x%0d", i), 32'h0, model_regs[i], rs1_data_o);
            compare($sformatf("reset_x%0d", 31 - i), 32'h0, model_regs[31 - i], rs2_data_o);
        end
        for (int i = 0; i < 4; i++) begin
            csr_raddr_i = writable[i];
            #1;
            compare($sformatf("reset_csr_%03h", writable[i]), 32'h0,
                    model_csr_read(writable[i]), csr_rdata_o);
        end
    endtask

    initial begin
        int          fd;
        int          r;
        int          op_lines;
        string       op;
        string       label;
        string       line;
        logic [31:0] f [8];

        clk_i         = 1'b0;
        rstn_i        = 1'b0;
        uop_i         = '0;
        alloc_valid_i = 1'b0;
        alloc_tag_i   = '0;
        rs1_addr_i    = '0;
        rs2_addr_i    = '0;
        csr_raddr_i   = '0;
        model_done    = '0;
        set_now       = '0;
        set_prev      = '0;
        clr_now       = '0;
        vector_errors = 0;
        model_errors  = 0;
        checks        = 0;
        since_uop     = 2;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end

        op_lines = 0;
        fd = $fopen(VECTOR_PATH, "r");
        if (fd == 0) begin
            $display("Could not open the vector file %s", VECTOR_PATH);
            vector_errors++;
        end else begin
            while ($fgets(line, fd) > 0) begin
                if (line.len() > 1 && line[0] != "#") begin
                    op_lines++;
                end
            end
            $fclose(fd);
            fd = $fopen(VECTOR_PATH, "r");
            if (fd == 0) begin
                $display("Could not reopen the vector file %s", VECTOR_PATH);
                vector_errors++;
            end
        end
        cycle_limit = op_lines * 4 + 20;

        repeat (10) @(negedge clk_i);
        rstn_i = 1'b1;
        sweep_after_reset();
        step_cycle();

        while (fd != 0 && $fscanf(fd, "%s", op) == 1) begin
            if (op[0] == "#") begin
                r = $fgets(line, fd);
            end else if (op == "U") begin
                r = $fscanf(fd, "%s %h %h %h %h %h %h %h %h", label,
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
                check_field_count(op, r, 9);
                uop_i = {f[7], f[6][11:0], f[5][0], f[4], f[3][4:0], f[2][0], f[1][3:0], f[0][0]};
                if (f[0][0] && f[2][0] && f[3][4:0] != 5'd0) begin
                    model_regs[f[3][4:0]] = f[4];
                end
                if (f[0][0] && f[5][0] && csr_writable(f[6][11:0])) begin
                    model_csrs[f[6][11:0]] = f[7];
                end
                if (f[0][0] && (f[2][0] || f[5][0])) begin
                    set_now = 16'h1 << f[1][3:0];
                end
                since_uop = 0;
                step_cycle();
            end else if (op == "A") begin
                r = $fscanf(fd, "%s %h", label, f[0]);
                check_field_count(op, r, 2);
                alloc_valid_i = 1'b1;
                alloc_tag_i   = f[0][3:0];
                clr_now       = 16'h1 << f[0][3:0];
                step_cycle();
            end else if (op == "R") begin
                r = $fscanf(fd, "%s %h %h", label, f[0], f[1]);
                check_field_count(op, r, 3);
                wait_for_writes();
                rs1_addr_i = f[0][4:0];
                rs2_addr_i = f[0][4:0];
                #(HALF_PERIOD / 2);
                compare({label, " rs1"}, f[1], model_regs[f[0][4:0]], rs1_data_o);
                compare({label, " rs2"}, f[1], model_regs[f[0][4:0]], rs2_data_o);
                step_cycle();
            end else if (op == "C") begin
                r = $fscanf(fd, "%s %h %h", label, f[0], f[1]);
                check_field_count(op, r, 3);
                wait_for_writes();
                csr_raddr_i = f[0][11:0];
                #(HALF_PERIOD / 2);
                compare(label, f[1], model_csr_read(f[0][11:0]), csr_rdata_o);
                step_cycle();
            end else if (op == "D") begin
                r = $fscanf(fd, "%s %h", label, f[0]);
                check_field_count(op, r, 2);
                wait_for_writes();
                #(HALF_PERIOD / 2);
                compare(label, {16'h0, f[0][15:0]}, {16'h0, model_done}, {16'h0, done_o});
                step_cycle();
            end else if (op == "I") begin
                r = $fscanf(fd, "%s %h", label, f[0]);
                check_field_count(op, r, 2);
                repeat (f[0]) step_cycle();
            end else begin
                $display("Unknown operation %s in the vector file", op);
                vector_errors++;
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        $display("Checks %0d, vector mismatches %0d, model mismatches %0d",
                 checks, vector_errors, model_errors);
        if (vector_errors == 0 && model_errors == 0 && checks > 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* verif/wb_vectors.txt */
# op label then hex fields; U: valid tag rd_alloc rd rd_data csr_alloc csr_addr csr_data
# A: tag   R: reg expected   C: csr_addr expected   D: done_vector   I: idle_cycles
D reset_done 0000
U wr_x1 1 1 1 01 11111111 0 000 00000000
U wr_x2 1 2 1 02 22222222 0 000 00000000
U wr_x0 1 3 1 00 deadbeef 0 000 00000000
U noalloc_x3 1 4 0 03 33333333 0 000 00000000
U novalid_x4 0 5 1 04 44444444 0 000 00000000
R rd_x1 01 11111111
R rd_x2 02 22222222
R rd_x0 00 00000000
R rd_x3 03 00000000
R rd_x4 04 00000000
D done_reg 000e
U wr_mtvec 1 6 0 00 00000000 1 305 80000100
U wr_mscratch 1 7 0 00 00000000 1 340 a5a5a5a5
U wr_mepc 1 8 0 00 00000000 1 341 00001234
U wr_mcause 1 9 0 00 00000000 1 342 0000000b
U wr_mhartid 1 a 0 00 00000000 1 f14 ffffffff
U wr_unimpl 1 b 0 00 00000000 1 7c0 12345678
C rd_mtvec 305 80000100
C rd_mscratch 340 a5a5a5a5
C rd_mepc 341 00001234
C rd_mcause 342 0000000b
C rd_mhartid f14 00000000
C rd_unimpl 7c0 00000000
D done_csr 0fce
U wr_both 1 c 1 05 cafef00d 1 340 0badf00d
R rd_both_x5 05 cafef00d
C rd_both_mscratch 340 0badf00d
D done_both 1fce
U b2b_x6_first 1 d 1 06 00000001 0 000 00000000
U b2b_x7 1 e 1 07 00000007 0 000 00000000
U b2b_x6_last 1 f 1 06 00000002 0 000 00000000
R rd_x6 06 00000002
R rd_x7 07 00000007
D done_b2b ffce
A alloc_1 1
D done_alloc ffcc
U rewb_tag1 1 1 1 08 00000008 0 000 00000000
D done_rewb ffce
A alloc_2 2
D done_alloc2 ffca
U race_tag2 1 2 1 09 00000009 0 000 00000000
A race_alloc_2 2
D done_race ffce
I idle_end 3
R rd_x9 09 00000009
